// ==== ov5640_cfg_pkg.sv ====
`default_nettype none

package ov5640_cfg_pkg;

    // One serial-bus write, address in the upper 16 bits
    typedef struct packed {
        logic [15:0] reg_addr;               // Sensor register address
        logic [7:0]  reg_val;                // Value written to that register
    } cfg_cmd_t;

    // Index into the register table, wide enough to rest one past the last entry
    typedef logic [6:0] cfg_index_t;

    localparam int CFG_REG_NUM     = 96;     // Writes in the power-up sequence
    localparam int CFG_WAIT_CYCLES = 30000;  // Settling cycles before first write
    localparam int CFG_WAIT_W      = 15;     // Settling counter width

endpackage

`default_nettype wire

// ==== ov5640_power_up_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module ov5640_power_up_timer (
    input  logic sys_clk,
    input  logic sys_rst_n,
    output logic wait_done
);
    import ov5640_cfg_pkg::*;

    localparam logic [CFG_WAIT_W-1:0] WAIT_LAST = CFG_WAIT_W'(CFG_WAIT_CYCLES - 1);
    localparam logic [CFG_WAIT_W-1:0] WAIT_MAX  = CFG_WAIT_W'(CFG_WAIT_CYCLES);

    logic [CFG_WAIT_W-1:0] wait_cnt;          // Cycles since reset release

    // Counter stops at the limit, so the pulse below cannot repeat
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wait_cnt <= '0;
        end else if (wait_cnt < WAIT_MAX) begin
            wait_cnt <= wait_cnt + 1'b1;      // Still settling
        end
    end

    // Registered pulse lands on the same edge the counter hits the limit
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wait_done <= 1'b0;
        end else begin
            wait_done <= (wait_cnt == WAIT_LAST); // High for one cycle only
        end
    end

endmodule

`default_nettype wire

// ==== ov5640_reg_table.sv ====
`timescale 1ns/10ps
`default_nettype none

module ov5640_reg_table (
    input  ov5640_cfg_pkg::cfg_index_t reg_index,
    output ov5640_cfg_pkg::cfg_cmd_t   cfg_data
);
    import ov5640_cfg_pkg::*;

    // Fixed write list; anything past the end reads back as a null command
    always_comb begin
        cfg_data = '0;                                         // Quiet after last write
        if (reg_index < cfg_index_t'(CFG_REG_NUM)) begin
            case (reg_index)
                7'd0:  cfg_data = {16'h3103, 8'h11};           // Clock source select
                7'd1:  cfg_data = {16'h3008, 8'h82};           // Software reset
                7'd2:  cfg_data = {16'h3008, 8'h02};           // Leave software reset
                7'd3:  cfg_data = {16'h3103, 8'h03};           // System clock from PLL
                7'd4:  cfg_data = {16'h3017, 8'hff};           // DVP pins as outputs
                7'd5:  cfg_data = {16'h3018, 8'hff};           // DVP pins as outputs
                7'd6:  cfg_data = {16'h3034, 8'h1a};           // PLL charge pump, bit div
                7'd7:  cfg_data = {16'h3035, 8'h21};           // System and MIPI dividers
                7'd8:  cfg_data = {16'h3036, 8'hb8};           // PLL multiplier
                7'd9:  cfg_data = {16'h3037, 8'h12};           // PLL root and pre-divider
                7'd10: cfg_data = {16'h3108, 8'h01};           // PCLK and SCLK dividers
                7'd11: cfg_data = {16'h3630, 8'h36};           // Analog setup
                7'd12: cfg_data = {16'h3631, 8'h0e};           // Analog setup
                7'd13: cfg_data = {16'h3632, 8'he2};           // Analog setup
                7'd14: cfg_data = {16'h3633, 8'h12};           // Analog setup
                7'd15: cfg_data = {16'h3621, 8'he0};           // Analog setup
                7'd16: cfg_data = {16'h3704, 8'ha0};           // Analog setup
                7'd17: cfg_data = {16'h3703, 8'h5a};           // Analog setup
                7'd18: cfg_data = {16'h3715, 8'h78};           // Analog setup
                7'd19: cfg_data = {16'h3717, 8'h01};           // Analog setup
                7'd20: cfg_data = {16'h370b, 8'h60};           // Analog setup
                7'd21: cfg_data = {16'h3705, 8'h1a};           // Analog setup
                7'd22: cfg_data = {16'h3905, 8'h02};           // Analog setup
                7'd23: cfg_data = {16'h3906, 8'h10};           // Analog setup
                7'd24: cfg_data = {16'h3901, 8'h0a};           // Analog setup
                7'd25: cfg_data = {16'h3731, 8'h12};           // Analog setup
                7'd26: cfg_data = {16'h3600, 8'h08};           // VCM control
                7'd27: cfg_data = {16'h3601, 8'h33};           // VCM control
                7'd28: cfg_data = {16'h302d, 8'h60};           // System control
                7'd29: cfg_data = {16'h3620, 8'h52};           // Analog setup
                7'd30: cfg_data = {16'h371b, 8'h20};           // Analog setup
                7'd31: cfg_data = {16'h471c, 8'h50};           // DVP control
                7'd32: cfg_data = {16'h3a13, 8'h60};           // AEC pre-gain
                7'd33: cfg_data = {16'h3a18, 8'h02};           // AEC gain ceiling high
                7'd34: cfg_data = {16'h3a19, 8'hff};           // AEC gain ceiling low
                7'd35: cfg_data = {16'h3635, 8'h13};           // Analog setup
                7'd36: cfg_data = {16'h3636, 8'h03};           // Analog setup
                7'd37: cfg_data = {16'h3634, 8'h40};           // Analog setup
                7'd38: cfg_data = {16'h3622, 8'h01};           // Analog setup
                7'd39: cfg_data = {16'h3c01, 8'h34};           // Light detect band ctrl
                7'd40: cfg_data = {16'h3c04, 8'h28};           // Light detect low sum
                7'd41: cfg_data = {16'h3c05, 8'h98};           // Light detect high sum
                7'd42: cfg_data = {16'h3c06, 8'h00};           // Lightmeter 1 thresh hi
                7'd43: cfg_data = {16'h3c07, 8'h08};           // Lightmeter 1 thresh lo
                7'd44: cfg_data = {16'h3c08, 8'h00};           // Lightmeter 2 thresh hi
                7'd45: cfg_data = {16'h3c09, 8'h1c};           // Lightmeter 2 thresh lo
                7'd46: cfg_data = {16'h3c0a, 8'h9c};           // Sample number hi
                7'd47: cfg_data = {16'h3c0b, 8'h40};           // Sample number lo
                7'd48: cfg_data = {16'h3820, 8'h41};           // Timing, vertical flip
                7'd49: cfg_data = {16'h3821, 8'h07};           // Timing, mirror, binning
                7'd50: cfg_data = {16'h3814, 8'h31};           // X subsample increment
                7'd51: cfg_data = {16'h3815, 8'h31};           // Y subsample increment
                7'd52: cfg_data = {16'h3800, 8'h00};           // Window X start hi
                7'd53: cfg_data = {16'h3801, 8'h00};           // Window X start lo
                7'd54: cfg_data = {16'h3802, 8'h00};           // Window Y start hi
                7'd55: cfg_data = {16'h3803, 8'h00};           // Window Y start lo
                7'd56: cfg_data = {16'h3804, 8'h0a};           // Window X end hi
                7'd57: cfg_data = {16'h3805, 8'h3f};           // Window X end lo
                7'd58: cfg_data = {16'h3806, 8'h07};           // Window Y end hi
                7'd59: cfg_data = {16'h3807, 8'h9b};           // Window Y end lo
                7'd60: cfg_data = {16'h3808, 8'h02};           // Output width hi
                7'd61: cfg_data = {16'h3809, 8'h80};           // Output width lo, 640
                7'd62: cfg_data = {16'h380a, 8'h01};           // Output height hi
                7'd63: cfg_data = {16'h380b, 8'he0};           // Output height lo, 480
                7'd64: cfg_data = {16'h380c, 8'h07};           // HTS hi
                7'd65: cfg_data = {16'h380d, 8'h68};           // HTS lo
                7'd66: cfg_data = {16'h380e, 8'h03};           // VTS hi
                7'd67: cfg_data = {16'h380f, 8'hd8};           // VTS lo
                7'd68: cfg_data = {16'h3810, 8'h00};           // ISP X offset hi
                7'd69: cfg_data = {16'h3811, 8'h10};           // ISP X offset lo
                7'd70: cfg_data = {16'h3812, 8'h00};           // ISP Y offset hi
                7'd71: cfg_data = {16'h3813, 8'h06};           // ISP Y offset lo
                7'd72: cfg_data = {16'h3618, 8'h00};           // Analog setup
                7'd73: cfg_data = {16'h3612, 8'h29};           // Analog setup
                7'd74: cfg_data = {16'h3708, 8'h64};           // Analog setup
                7'd75: cfg_data = {16'h3709, 8'h52};           // Analog setup
                7'd76: cfg_data = {16'h370c, 8'h03};           // Analog setup
                7'd77: cfg_data = {16'h3a02, 8'h03};           // AEC 60 Hz max expo hi
                7'd78: cfg_data = {16'h3a03, 8'hd8};           // AEC 60 Hz max expo lo
                7'd79: cfg_data = {16'h3a08, 8'h02};           // AEC 50 Hz band step hi
                7'd80: cfg_data = {16'h3a09, 8'h40};           // AEC 50 Hz band step lo
                7'd81: cfg_data = {16'h3a0a, 8'h01};           // AEC 60 Hz band step hi
                7'd82: cfg_data = {16'h3a0b, 8'hf6};           // AEC 60 Hz band step lo
                7'd83: cfg_data = {16'h3a0e, 8'h03};           // AEC 50 Hz max bands
                7'd84: cfg_data = {16'h3a0d, 8'h04};           // AEC 60 Hz max bands
                7'd85: cfg_data = {16'h3a14, 8'h03};           // AEC 50 Hz max expo hi
                7'd86: cfg_data = {16'h3a15, 8'hd8};           // AEC 50 Hz max expo lo
                7'd87: cfg_data = {16'h3000, 8'h00};           // Block resets released
                7'd88: cfg_data = {16'h3002, 8'h1c};           // Block resets, FIFO side
                7'd89: cfg_data = {16'h3004, 8'hff};           // Block clock enables
                7'd90: cfg_data = {16'h3006, 8'hc3};           // Block clock enables
                7'd91: cfg_data = {16'h300e, 8'h58};           // DVP on, MIPI powered down
                7'd92: cfg_data = {16'h302e, 8'h00};           // System control
                7'd93: cfg_data = {16'h3c01, 8'hb4};           // Band detect manual mode
                7'd94: cfg_data = {16'h3c00, 8'h04};           // Band select, 50 Hz
                7'd95: cfg_data = {16'h3022, 8'h01};           // MCU command, last write
                default: cfg_data = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== ov5640_cfg_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module ov5640_cfg_sequencer (
    input  logic                       sys_clk,
    input  logic                       sys_rst_n,
    input  logic                       wait_done,   // One pulse once the sensor has settled
    input  logic                       cfg_end,     // Current write finished on the bus
    output ov5640_cfg_pkg::cfg_index_t reg_index,
    output logic                       cfg_start,
    output logic                       cfg_done
);
    import ov5640_cfg_pkg::*;

    localparam cfg_index_t LAST_INDEX = cfg_index_t'(CFG_REG_NUM);

    cfg_index_t next_index;                           // Index after the current write
    logic       end_accept;                           // cfg_end that belongs to the sequence
    logic       last_write;                           // Current write is the final one

    // After completion the bus may still toggle cfg_end, those pulses are dropped
    assign end_accept = cfg_end && !cfg_done;
    assign next_index = reg_index + 1'b1;
    assign last_write = (next_index >= LAST_INDEX);

    // Write index, rests at CFG_REG_NUM so the table returns zero
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            reg_index <= '0;
        end else if (end_accept) begin
            reg_index <= next_index;                  // Move to the next table entry
        end
    end

    // Start pulse, first from the settling timer, then one cycle after each cfg_end
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cfg_start <= 1'b0;
        end else if (wait_done) begin
            cfg_start <= 1'b1;                        // Kick off entry 0
        end else if (end_accept && !last_write) begin
            cfg_start <= 1'b1;                        // More writes left
        end else begin
            cfg_start <= 1'b0;                        // Pulse is one cycle wide
        end
    end

    // Completion flag, sticky until reset
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cfg_done <= 1'b0;
        end else if (end_accept && last_write) begin
            cfg_done <= 1'b1;                         // Same edge as the final index step
        end
    end

endmodule

`default_nettype wire

// ==== ov5640_cfg_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module ov5640_cfg_top (
    input  logic                     sys_clk,
    input  logic                     sys_rst_n,
    input  logic                     cfg_end,     // From the serial-bus master
    output logic                     cfg_start,   // Write request to the master
    output ov5640_cfg_pkg::cfg_cmd_t cfg_data,    // Address and value of the write
    output logic                     cfg_done     // Whole sequence written
);
    import ov5640_cfg_pkg::*;

    logic       wait_done;                        // Settling time elapsed
    cfg_index_t reg_index;                        // Table entry being written

    // Power-up settling delay
    ov5640_power_up_timer i_timer (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .wait_done (wait_done)
    );

    // Steps through the table, one bus write at a time
    ov5640_cfg_sequencer i_sequencer (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .wait_done (wait_done),
        .cfg_end   (cfg_end),
        .reg_index (reg_index),
        .cfg_start (cfg_start),
        .cfg_done  (cfg_done)
    );

    // Register list, combinational
    ov5640_reg_table i_reg_table (
        .reg_index (reg_index),
        .cfg_data  (cfg_data)
    );

endmodule

`default_nettype wire

// ==== ov5640_cfg_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module ov5640_cfg_checker (
    input logic                       sys_clk,
    input logic                       sys_rst_n,
    input ov5640_cfg_pkg::cfg_index_t reg_index,
    input logic                       cfg_start,
    input logic                       cfg_done
);
    import ov5640_cfg_pkg::*;

    int unsigned fail_cnt;                           // Polled by the testbench

    initial fail_cnt = 0;

    start_one_cycle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        cfg_start |=> !cfg_start)
        else begin
            fail_cnt++;
            $error("cfg_start wider than one cycle");
        end

    no_start_when_done: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        !(cfg_start && cfg_done))
        else begin
            fail_cnt++;
            $error("cfg_start while cfg_done is high");
        end

    // Done is sticky until the next reset
    done_sticky: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        cfg_done |=> cfg_done)
        else begin
            fail_cnt++;
            $error("cfg_done fell without reset");
        end

    index_bound: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        reg_index <= cfg_index_t'(CFG_REG_NUM))
        else begin
            fail_cnt++;
            $error("reg_index beyond table length");
        end

endmodule

bind ov5640_cfg_sequencer ov5640_cfg_checker i_checker (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .reg_index (reg_index),
    .cfg_start (cfg_start),
    .cfg_done  (cfg_done)
);

`default_nettype wire

// ==== tb_ov5640_cfg.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ov5640_cfg;
    import ov5640_cfg_pkg::*;

    logic     sys_clk;
    logic     sys_rst_n;
    logic     cfg_end;                               // Driven by the master model
    logic     cfg_start;
    cfg_cmd_t cfg_data;
    logic     cfg_done;

    int seed;                                        // Random stream for master delays
    int start_count;                                 // Starts seen since last reset

    ov5640_cfg_top i_dut (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .cfg_end   (cfg_end),
        .cfg_start (cfg_start),
        .cfg_data  (cfg_data),
        .cfg_done  (cfg_done)
    );

    always #10 sys_clk = ~sys_clk;                   // 20 ns period

    // Expected write for one position in the sequence
    // Only spot entries are known exactly, the rest need a nonzero address
    function automatic cfg_cmd_t expected_cmd(input int idx, output logic exact);
        cfg_cmd_t cmd;
        cmd   = '0;
        exact = 1'b1;
        if (idx < CFG_REG_NUM) begin
            case (idx)
                0:       cmd = {16'h3103, 8'h11};   // Clock source
                1:       cmd = {16'h3008, 8'h82};   // Soft reset on
                2:       cmd = {16'h3008, 8'h02};   // Soft reset off
                8:       cmd = {16'h3036, 8'hb8};   // PLL multiplier
                52:      cmd = {16'h3800, 8'h00};   // Window X start
                60:      cmd = {16'h3808, 8'h02};   // Output width hi
                95:      cmd = {16'h3022, 8'h01};   // Last write
                default: exact = 1'b0;
            endcase
        end
        return cmd;                                  // Past the table the command is zero
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Errors found");
        $fatal(1, "Wait limit reached");
    endtask

    // Compare process, every start is checked against the reference
    always @(negedge sys_clk) begin
        cfg_cmd_t exp_cmd;
        logic     exact;
        if (!sys_rst_n) begin
            start_count = 0;                         // New sequence after reset
        end else begin
            check_value(32'(i_dut.i_sequencer.i_checker.fail_cnt), 32'd0,
                        "sequencer assertion failures");
            if (cfg_start) begin
                check_value(32'(start_count < CFG_REG_NUM), 32'd1, "start within table");
                exp_cmd = expected_cmd(start_count, exact);
                if (exact) begin
                    check_value(32'(cfg_data), 32'(exp_cmd), "cfg_data at start");
                end else begin
                    check_value(32'(cfg_data.reg_addr != 16'h0000), 32'd1,
                                "nonzero address at start");
                end
                start_count = start_count + 1;
            end
        end
    end

    // Hold reset for 8 cycles, outputs must stay cleared, index back at entry 0
    task automatic apply_reset();
        logic     exact;
        cfg_cmd_t first_cmd;
        first_cmd = expected_cmd(0, exact);
        sys_rst_n = 1'b0;
        cfg_end   = 1'b0;
        repeat (8) begin
            @(negedge sys_clk);
            check_value(32'(cfg_start), 32'd0, "cfg_start during reset");
            check_value(32'(cfg_done), 32'd0, "cfg_done during reset");
            check_value(32'(cfg_data), 32'(first_cmd), "cfg_data during reset");
        end
        sys_rst_n = 1'b1;                            // Released on a falling edge
    endtask

    // Count edges from reset release to the first start
    task automatic wait_first_start();
        int   edges;
        logic seen;
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < CFG_WAIT_CYCLES + 100) begin
            @(negedge sys_clk);
            edges = edges + 1;                       // One rising edge per falling edge
            check_value(32'(cfg_done), 32'd0, "cfg_done while settling");
            seen = cfg_start;
        end
        if (!seen) begin
            report_timeout("the first cfg_start after reset release");
        end else begin
            check_value(32'(edges), 32'(CFG_WAIT_CYCLES + 1), "edges to first cfg_start");
        end
    endtask

    // Serial master: answer each start after 2 to 20 cycles
    task automatic serve_writes(input int num_writes);
        cfg_cmd_t held_cmd;
        int       delay;
        logic     more;
        for (int k = 0; k < num_writes; k++) begin
            held_cmd = cfg_data;                     // Sampled with the start
            delay    = 2 + int'($unsigned($random(seed)) % 19);
            repeat (delay) begin
                @(negedge sys_clk);
                check_value(32'(cfg_start), 32'd0, "cfg_start while write busy");
                check_value(32'(cfg_data), 32'(held_cmd), "cfg_data stable until cfg_end");
            end
            cfg_end = 1'b1;
            @(negedge sys_clk);
            cfg_end = 1'b0;
            more    = (k + 1 < CFG_REG_NUM);
            check_value(32'(cfg_start), 32'(more), "cfg_start one cycle after cfg_end");
            check_value(32'(cfg_done), 32'(!more), "cfg_done one cycle after cfg_end");
        end
    endtask

    // After completion nothing may move
    task automatic check_quiet();
        check_value(32'(cfg_start), 32'd0, "cfg_start after done");
        check_value(32'(cfg_done), 32'd1, "cfg_done held");
        check_value(32'(cfg_data), 32'd0, "cfg_data after done");
    endtask

    task automatic send_stray_ends(input int count);
        int gap;
        check_quiet();
        for (int n = 0; n < count; n++) begin
            gap = 3 + int'($unsigned($random(seed)) % 8);
            repeat (gap) begin
                @(negedge sys_clk);
                check_quiet();
            end
            cfg_end = 1'b1;                          // Stray pulse, must be ignored
            @(negedge sys_clk);
            cfg_end = 1'b0;
            check_quiet();
        end
        repeat (4) begin
            @(negedge sys_clk);
            check_quiet();
        end
        check_value(32'(start_count), 32'(CFG_REG_NUM), "number of starts");
    endtask

    initial begin
        seed        = 68;
        start_count = 0;
        sys_clk     = 1'b0;
        sys_rst_n   = 1'b0;
        cfg_end     = 1'b0;
        repeat (8) @(negedge sys_clk);
        sys_rst_n = 1'b1;

        wait_first_start();                          // Full sequence
        serve_writes(CFG_REG_NUM);
        send_stray_ends(3);

        apply_reset();                               // Partial sequence
        wait_first_start();
        serve_writes(37);
        repeat (2) @(negedge sys_clk);
        apply_reset();                               // Reset mid-write

        wait_first_start();                          // Restart from entry 0
        serve_writes(CFG_REG_NUM);
        send_stray_ends(2);

        repeat (4) @(negedge sys_clk);
        if (i_dut.i_sequencer.i_checker.fail_cnt != 0) begin
            $display("Sequencer assertions failed %0d times",
                     i_dut.i_sequencer.i_checker.fail_cnt);
            $display("Errors found");
            $fatal(1, "Assertion failures");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
ov5640_cfg_pkg.sv
ov5640_power_up_timer.sv
ov5640_reg_table.sv
ov5640_cfg_sequencer.sv
ov5640_cfg_top.sv
ov5640_cfg_checker.sv
tb_ov5640_cfg.sv

// ==== Makefile ====
# Verilator flow for the OV5640 register-load sequencer

VERILATOR  ?= verilator
FLAGS      ?= --timing --assert
TOP        := tb_ov5640_cfg
RTL_TOP    := ov5640_cfg_top
FLIST      := flist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
